/* dv/ex_tests.txt */
# pc pc_next rd imm_i imm_j alu f3 res op1 op2 wr jal jalr br st reg1 reg2, all hex
# then expected: redirect target result rd wr st
100 104 01 0        0        0 0 0 0 0 1 0 0 0 0 5        7        0 100      c        01 1 0
104 108 02 0        0        1 0 0 0 0 1 0 0 0 0 5        7        0 104      fffffffe 02 1 0
108 10c 03 0        0        2 0 0 0 0 1 0 0 0 0 3        24       0 108      30       03 1 0
10c 110 04 0        0        3 0 0 0 0 1 0 0 0 0 ffffffff 1        0 10c      1        04 1 0
110 114 05 0        0        4 0 0 0 0 1 0 0 0 0 ffffffff 1        0 110      0        05 1 0
114 118 06 0        0        5 0 0 0 0 1 0 0 0 0 f0f0f0f0 ff00ff00 0 114      0ff00ff0 06 1 0
118 11c 07 0        0        6 0 0 0 0 1 0 0 0 0 80000000 4        0 118      08000000 07 1 0
11c 120 08 0        0        7 0 0 0 0 1 0 0 0 0 80000000 4        0 11c      f8000000 08 1 0
120 124 09 0        0        8 0 0 0 0 1 0 0 0 0 f0f0f0f0 ffff     0 120      f0f0ffff 09 1 0
124 128 0a 0        0        9 0 0 0 0 1 0 0 0 0 f0f0f0f0 ffff     0 124      0000f0f0 0a 1 0
128 12c 0b fffffff0 0        0 0 0 0 1 1 0 0 0 0 100      0        0 128      f0       0b 1 0
12c 130 0c 0        12000    0 0 0 1 2 1 0 0 0 0 0        0        0 1212c    1212c    0c 1 0
130 134 0d 0        abcde000 a 0 0 0 2 1 0 0 0 0 0        0        0 abcde130 abcde000 0d 1 0
134 138 01 0        100      0 0 1 0 0 1 1 0 0 0 0        0        1 234      138      01 1 0
138 13c 01 11       0        0 0 1 0 0 1 0 1 0 0 1000     0        1 1010     13c      01 1 0
13c 140 00 0        40       0 0 0 0 0 0 0 0 1 0 5        5        1 17c      0        00 0 0
140 144 00 0        fffffff0 0 1 0 0 0 0 0 0 1 0 5        5        0 130      0        00 0 0
144 148 00 0        20       0 4 0 0 0 0 0 0 1 0 ffffffff 1        1 164      0        00 0 0
148 14c 00 0        20       0 5 0 0 0 0 0 0 1 0 ffffffff 1        0 168      0        00 0 0
14c 150 00 0        8        0 6 0 0 0 0 0 0 1 0 ffffffff 1        0 154      0        00 0 0
150 154 00 0        8        0 7 0 0 0 0 0 0 1 0 ffffffff 1        1 158      0        00 0 0
154 158 00 8        0        0 0 0 0 1 0 0 0 0 1 2000     deadbeef 0 154      0        00 0 1
158 15c 0e 1        0        0 0 0 0 1 1 0 0 0 0 7fffffff 0        0 158      80000000 0e 1 0

/* sim.f */
logic/rv_types_pkg.sv
logic/rv_ctrl_pkg.sv
logic/ex_operand_stage.sv
logic/ex_branch_unit.sv
logic/ex_alu.sv
logic/ex_top.sv
dv/tb_clock_gen.sv
dv/ex_props.sv
dv/ex_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module ex_tb -f sim.f \
    && { ./obj_dir/Vex_tb > sim.log 2>&1 || true; } \
    && cat sim.log \
    && ! grep -q "TB FAILED" sim.log \
    && grep -q "TB PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* dv/ex_tb.sv */
`timescale 1ns/1ps

module ex_tb
    import rv_types_pkg::*, rv_ctrl_pkg::*;
;

    localparam int MAX_VEC    = 64;
    localparam int NUM_FIELDS = 23;

    logic      i_clk;
    logic      i_reset_n;
    word_t     i_pc;
    word_t     i_pc_next;
    reg_addr_t i_rd;
    word_t     i_imm_i;
    word_t     i_imm_j;
    alu_ctrl_t i_alu_ctrl;
    funct3_t   i_funct3;
    res_src_t  i_res_src;
    op1_sel_t  i_op1_src;
    op2_sel_t  i_op2_src;
    logic      i_reg_write;
    logic      i_inst_jal;
    logic      i_inst_jalr;
    logic      i_inst_branch;
    logic      i_inst_store;
    word_t     i_reg1_data;
    word_t     i_reg2_data;
    logic      o_redirect;
    word_t     o_redirect_pc;
    word_t     o_result;
    reg_addr_t o_rd;
    logic      o_reg_write;
    logic      o_store;
    word_t     o_store_data;

    // Columns 0 to 16 are stimulus, 17 to 22 are expected values
    word_t     vec [0:MAX_VEC][0:NUM_FIELDS-1];
    int        n_vec;

    tb_clock_gen u_clock_gen (.o_clk(i_clk));

    ex_top dut0 (.*);

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
            stop_with_failure($sformatf("MISMATCH at time %0t: %s is %h, expected %h",
                                        $time, what, got, exp));
    endtask

    task automatic compare_addr(input reg_addr_t got, input reg_addr_t exp, input string what);
        if (got !== exp)
            stop_with_failure($sformatf("MISMATCH at time %0t: %s is %0d, expected %0d",
                                        $time, what, got, exp));
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_with_failure($sformatf("MISMATCH at time %0t: %s is %b, expected %b",
                                        $time, what, got, exp));
    endtask

    task automatic load_vectors();
        int    fd;
        int    count;
        string line;
        word_t f [0:NUM_FIELDS-1];
        fd = $fopen("dv/ex_tests.txt", "r");
        if (fd == 0)
            stop_with_failure("could not open dv/ex_tests.txt");
        n_vec = 0;
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if ((line.len() > 1) && (line.substr(0, 0) != "#"))
            begin
                if (n_vec >= MAX_VEC)
                    stop_with_failure("too many vectors in dv/ex_tests.txt");
                count = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                    f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22]);
                if (count != NUM_FIELDS)
                    stop_with_failure($sformatf("vector %0d has %0d fields", n_vec, count));
                vec[n_vec] = f;
                n_vec++;
            end
        end
        $fclose(fd);
        if (n_vec == 0)
            stop_with_failure("dv/ex_tests.txt holds no vectors");
    endtask

    task automatic drive_decode(input int v);
        i_pc          <= vec[v][0];
        i_pc_next     <= vec[v][1];
        i_rd          <= vec[v][2][4:0];
        i_imm_i       <= vec[v][3];
        i_imm_j       <= vec[v][4];
        i_alu_ctrl    <= vec[v][5][3:0];
        i_funct3      <= vec[v][6][2:0];
        i_res_src     <= vec[v][7][0];
        i_op1_src     <= vec[v][8][0];
        i_op2_src     <= vec[v][9][1:0];
        i_reg_write   <= vec[v][10][0];
        i_inst_jal    <= vec[v][11][0];
        i_inst_jalr   <= vec[v][12][0];
        i_inst_branch <= vec[v][13][0];
        i_inst_store  <= vec[v][14][0];
    endtask

    task automatic drive_regs(input int v);
        i_reg1_data <= vec[v][15];
        i_reg2_data <= vec[v][16];
    endtask

    task automatic apply_reset();
        int cycles;
        i_reset_n <= 1'b0;
        repeat (5) @(posedge i_clk);
        i_reset_n <= 1'b1;
        cycles = 0;
        do
        begin
            @(negedge i_clk);
            cycles++;
            if (cycles > 10)
                stop_with_failure("reset was not released within 10 cycles");
        end
        while (dut0.i_reset_n !== 1'b1);
    endtask

    task automatic check_redirect(input int v);
        compare_bit(o_redirect, vec[v][17][0], $sformatf("vector %0d o_redirect", v));
        compare_word(o_redirect_pc, vec[v][18], $sformatf("vector %0d o_redirect_pc", v));
    endtask

    task automatic check_writeback(input int v);
        compare_bit(o_reg_write, vec[v][21][0], $sformatf("vector %0d o_reg_write", v));
        compare_bit(o_store, vec[v][22][0], $sformatf("vector %0d o_store", v));
        if (vec[v][21][0])
        begin
            compare_word(o_result, vec[v][19], $sformatf("vector %0d o_result", v));
            compare_addr(o_rd, vec[v][20][4:0], $sformatf("vector %0d o_rd", v));
        end
        if (vec[v][22][0])
            compare_word(o_store_data, vec[v][16], $sformatf("vector %0d o_store_data", v));
    endtask

    initial
    begin
        for (int r = 0; r <= MAX_VEC; r++)
        begin
            for (int c = 0; c < NUM_FIELDS; c++)
                vec[r][c] = '0;
        end
        load_vectors();
        drive_decode(n_vec);                                   // The row after the last vector is idle
        drive_regs(n_vec);
        apply_reset();
        compare_bit(o_reg_write, 1'b0, "o_reg_write after reset");
        compare_bit(o_store, 1'b0, "o_store after reset");
        compare_bit(o_redirect, 1'b0, "o_redirect after reset");

        // Register data trails its decode fields by one edge, write-back by two
        for (int k = 0; k <= n_vec + 1; k++)
        begin
            @(posedge i_clk);
            drive_decode((k < n_vec) ? k : n_vec);
            drive_regs(((k >= 1) && (k <= n_vec)) ? k - 1 : n_vec);
            @(negedge i_clk);
            if ((k >= 1) && (k <= n_vec))
                check_redirect(k - 1);
            if (k >= 2)
                check_writeback(k - 2);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

/* dv/ex_props.sv */
`timescale 1ns/1ps

module ex_props
    import rv_types_pkg::*;
(
    input logic  i_clk,
    input logic  i_reset_n,
    input logic  i_redirect,
    input word_t i_redirect_pc,
    input logic  i_reg_write,
    input logic  i_store
);

    reset_idle: assert property (@(posedge i_clk) !i_reset_n |=> !i_reg_write && !i_redirect)
        else $error("write enable or redirect high in the cycle after a reset edge");

    // Jump and branch targets are halfword aligned at least
    target_aligned: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_redirect |-> !i_redirect_pc[0])
        else $error("redirect target has bit 0 set");

    store_or_write: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(i_store && i_reg_write))
        else $error("store and register write are high together");

endmodule

bind ex_top ex_props u_props
(
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_redirect    (o_redirect),
    .i_redirect_pc (o_redirect_pc),
    .i_reg_write   (o_reg_write),
    .i_store       (o_store)
);

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic o_clk
);

    initial
    begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;                             // Half of the 4 ns period
    end

endmodule

/* logic/ex_top.sv */
`timescale 1ns/1ps

module ex_top
    import rv_types_pkg::*, rv_ctrl_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset_n,
    input  word_t     i_pc,
    input  word_t     i_pc_next,
    input  reg_addr_t i_rd,
    input  word_t     i_imm_i,
    input  word_t     i_imm_j,
    input  alu_ctrl_t i_alu_ctrl,
    input  funct3_t   i_funct3,
    input  res_src_t  i_res_src,
    input  op1_sel_t  i_op1_src,
    input  op2_sel_t  i_op2_src,
    input  logic      i_reg_write,
    input  logic      i_inst_jal,
    input  logic      i_inst_jalr,
    input  logic      i_inst_branch,
    input  logic      i_inst_store,
    input  word_t     i_reg1_data,
    input  word_t     i_reg2_data,
    output logic      o_redirect,
    output word_t     o_redirect_pc,
    output word_t     o_result,
    output reg_addr_t o_rd,
    output logic      o_reg_write,
    output logic      o_store,
    output word_t     o_store_data
);

    word_t     ex_op1;
    word_t     ex_op2;
    word_t     ex_pc_target;
    word_t     ex_pc_next;
    reg_addr_t ex_rd;
    alu_ctrl_t ex_alu_ctrl;
    funct3_t   ex_funct3;
    res_src_t  ex_res_src;
    logic      ex_reg_write;
    logic      ex_store;
    logic      ex_inst_jump;
    logic      ex_inst_branch;
    word_t     ex_store_data;

    ex_operand_stage u_operand_stage
    (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_pc          (i_pc),
        .i_pc_next     (i_pc_next),
        .i_rd          (i_rd),
        .i_imm_i       (i_imm_i),
        .i_imm_j       (i_imm_j),
        .i_alu_ctrl    (i_alu_ctrl),
        .i_funct3      (i_funct3),
        .i_res_src     (i_res_src),
        .i_op1_src     (i_op1_src),
        .i_op2_src     (i_op2_src),
        .i_reg_write   (i_reg_write),
        .i_inst_jal    (i_inst_jal),
        .i_inst_jalr   (i_inst_jalr),
        .i_inst_branch (i_inst_branch),
        .i_inst_store  (i_inst_store),
        .i_reg1_data   (i_reg1_data),
        .i_reg2_data   (i_reg2_data),
        .o_op1         (ex_op1),
        .o_op2         (ex_op2),
        .o_pc_target   (ex_pc_target),
        .o_pc_next     (ex_pc_next),
        .o_rd          (ex_rd),
        .o_alu_ctrl    (ex_alu_ctrl),
        .o_funct3      (ex_funct3),
        .o_res_src     (ex_res_src),
        .o_reg_write   (ex_reg_write),
        .o_store       (ex_store),
        .o_inst_jump   (ex_inst_jump),
        .o_inst_branch (ex_inst_branch),
        .o_store_data  (ex_store_data)
    );

    ex_branch_unit u_branch_unit
    (
        .i_inst_jump   (ex_inst_jump),
        .i_inst_branch (ex_inst_branch),
        .i_funct3      (ex_funct3),
        .i_reg1_data   (i_reg1_data),
        .i_reg2_data   (i_reg2_data),
        .i_pc_target   (ex_pc_target),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

    ex_alu u_alu
    (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_op1        (ex_op1),
        .i_op2        (ex_op2),
        .i_alu_ctrl   (ex_alu_ctrl),
        .i_res_src    (ex_res_src),
        .i_pc_next    (ex_pc_next),
        .i_rd         (ex_rd),
        .i_reg_write  (ex_reg_write),
        .i_store      (ex_store),
        .i_store_data (ex_store_data),
        .o_result     (o_result),
        .o_rd         (o_rd),
        .o_reg_write  (o_reg_write),
        .o_store      (o_store),
        .o_store_data (o_store_data)
    );

endmodule

/* logic/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu
    import rv_types_pkg::*, rv_ctrl_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset_n,
    input  word_t     i_op1,
    input  word_t     i_op2,
    input  alu_ctrl_t i_alu_ctrl,
    input  res_src_t  i_res_src,
    input  word_t     i_pc_next,
    input  reg_addr_t i_rd,
    input  logic      i_reg_write,
    input  logic      i_store,
    input  word_t     i_store_data,
    output word_t     o_result,
    output reg_addr_t o_rd,
    output logic      o_reg_write,
    output logic      o_store,
    output word_t     o_store_data
);

    logic [4:0] shamt;
    word_t      alu_out;
    word_t      result;

    assign shamt = i_op2[4:0];

    always_comb
    begin
        case (i_alu_ctrl)
            ALU_ADD:  alu_out = i_op1 + i_op2;
            ALU_SUB:  alu_out = i_op1 - i_op2;
            ALU_SLL:  alu_out = i_op1 << shamt;
            ALU_SLT:  alu_out = {31'd0, $signed(i_op1) < $signed(i_op2)};
            ALU_SLTU: alu_out = {31'd0, i_op1 < i_op2};
            ALU_XOR:  alu_out = i_op1 ^ i_op2;
            ALU_SRL:  alu_out = i_op1 >> shamt;
            ALU_SRA:  alu_out = word_t'($signed(i_op1) >>> shamt);
            ALU_OR:   alu_out = i_op1 | i_op2;
            ALU_AND:  alu_out = i_op1 & i_op2;
            ALU_PASS: alu_out = i_op2;
            default:  alu_out = '0;
        endcase
    end

    assign result = (i_res_src == RES_PC_NEXT) ? i_pc_next : alu_out;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_reg_write <= 1'b0;
            o_store     <= 1'b0;
        end
        else
        begin
            o_reg_write <= i_reg_write;
            o_store     <= i_store;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_result     <= result;
        o_rd         <= i_rd;
        o_store_data <= i_store_data;                          // Store address path belongs to the memory stage
    end

endmodule

/* logic/ex_branch_unit.sv */
`timescale 1ns/1ps

module ex_branch_unit
    import rv_types_pkg::*, rv_ctrl_pkg::*;
(
    input  logic    i_inst_jump,
    input  logic    i_inst_branch,
    input  funct3_t i_funct3,
    input  word_t   i_reg1_data,
    input  word_t   i_reg2_data,
    input  word_t   i_pc_target,
    output logic    o_redirect,
    output word_t   o_redirect_pc
);

    logic eq;
    logic lt;
    logic ltu;
    logic taken;

    assign eq  = (i_reg1_data == i_reg2_data);
    assign lt  = ($signed(i_reg1_data) < $signed(i_reg2_data));
    assign ltu = (i_reg1_data < i_reg2_data);

    always_comb
    begin
        case (i_funct3)
            F3_BEQ:  taken = eq;
            F3_BNE:  taken = !eq;
            F3_BLT:  taken = lt;
            F3_BGE:  taken = !lt;
            F3_BLTU: taken = ltu;
            F3_BGEU: taken = !ltu;
            default: taken = 1'b0;                             // 010 and 011 are not branches
        endcase
    end

    assign o_redirect    = i_inst_jump | (i_inst_branch & taken);
    assign o_redirect_pc = i_pc_target;

endmodule

/* logic/ex_operand_stage.sv */
`timescale 1ns/1ps

module ex_operand_stage
    import rv_types_pkg::*, rv_ctrl_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset_n,
    input  word_t     i_pc,
    input  word_t     i_pc_next,
    input  reg_addr_t i_rd,
    input  word_t     i_imm_i,
    input  word_t     i_imm_j,
    input  alu_ctrl_t i_alu_ctrl,
    input  funct3_t   i_funct3,
    input  res_src_t  i_res_src,
    input  op1_sel_t  i_op1_src,
    input  op2_sel_t  i_op2_src,
    input  logic      i_reg_write,
    input  logic      i_inst_jal,
    input  logic      i_inst_jalr,
    input  logic      i_inst_branch,
    input  logic      i_inst_store,
    input  word_t     i_reg1_data,
    input  word_t     i_reg2_data,
    output word_t     o_op1,
    output word_t     o_op2,
    output word_t     o_pc_target,
    output word_t     o_pc_next,
    output reg_addr_t o_rd,
    output alu_ctrl_t o_alu_ctrl,
    output funct3_t   o_funct3,
    output res_src_t  o_res_src,
    output logic      o_reg_write,
    output logic      o_store,
    output logic      o_inst_jump,
    output logic      o_inst_branch,
    output word_t     o_store_data
);

    word_t     pc;
    word_t     imm_i;
    word_t     imm_j;
    op1_sel_t  op1_sel;
    op2_sel_t  op2_sel;
    logic      inst_jal;
    logic      inst_jalr;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_reg_write   <= 1'b0;
            o_store       <= 1'b0;
            inst_jal      <= 1'b0;
            inst_jalr     <= 1'b0;
            o_inst_branch <= 1'b0;
        end
        else
        begin
            o_reg_write   <= i_reg_write;
            o_store       <= i_inst_store;
            inst_jal      <= i_inst_jal;
            inst_jalr     <= i_inst_jalr;
            o_inst_branch <= i_inst_branch;
        end
    end

    always_ff @(posedge i_clk)
    begin
        pc         <= i_pc;
        o_pc_next  <= i_pc_next;
        o_rd       <= i_rd;
        imm_i      <= i_imm_i;
        imm_j      <= i_imm_j;
        o_alu_ctrl <= i_alu_ctrl;
        o_funct3   <= i_funct3;
        o_res_src  <= i_res_src;
        op1_sel    <= i_op1_src;
        op2_sel    <= i_op2_src;
    end

    assign o_op1 = (op1_sel == OP1_PC) ? pc : i_reg1_data;     // Register data arrives a cycle late

    always_comb
    begin
        case (op2_sel)
            OP2_IMM_I: o_op2 = imm_i;
            OP2_IMM_J: o_op2 = imm_j;
            default:   o_op2 = i_reg2_data;
        endcase
    end

    // jalr clears bit 0 of the sum, branches and jal are PC relative
    assign o_pc_target = inst_jalr ? ((i_reg1_data + imm_i) & ~32'd1) : (pc + imm_j);

    assign o_inst_jump  = inst_jal | inst_jalr;
    assign o_store_data = i_reg2_data;

endmodule

/* logic/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

    typedef logic [3:0] alu_ctrl_t;
    typedef logic       op1_sel_t;
    typedef logic [1:0] op2_sel_t;
    typedef logic       res_src_t;
    typedef logic [2:0] funct3_t;

    localparam alu_ctrl_t ALU_ADD  = 4'd0;
    localparam alu_ctrl_t ALU_SUB  = 4'd1;
    localparam alu_ctrl_t ALU_SLL  = 4'd2;
    localparam alu_ctrl_t ALU_SLT  = 4'd3;
    localparam alu_ctrl_t ALU_SLTU = 4'd4;
    localparam alu_ctrl_t ALU_XOR  = 4'd5;
    localparam alu_ctrl_t ALU_SRL  = 4'd6;
    localparam alu_ctrl_t ALU_SRA  = 4'd7;
    localparam alu_ctrl_t ALU_OR   = 4'd8;
    localparam alu_ctrl_t ALU_AND  = 4'd9;
    localparam alu_ctrl_t ALU_PASS = 4'd10;                    // Operand 2 straight through, used by lui

    localparam op1_sel_t OP1_REG = 1'b0;
    localparam op1_sel_t OP1_PC  = 1'b1;

    localparam op2_sel_t OP2_REG   = 2'd0;
    localparam op2_sel_t OP2_IMM_I = 2'd1;
    localparam op2_sel_t OP2_IMM_J = 2'd2;

    localparam res_src_t RES_ALU     = 1'b0;
    localparam res_src_t RES_PC_NEXT = 1'b1;                   // Link value for jal and jalr

    // Branch conditions use the RV32I funct3 encodings
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

endpackage

/* logic/rv_types_pkg.sv */
package rv_types_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Data word, PC value or sign-extended immediate
    typedef logic [XLEN-1:0]       word_t;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;                 // Index into the 32-entry register file

endpackage
